/* Bender.yml */
package:
  name: i2s_rx

sources:
  - design/i2s_rx_pkg.sv
  - design/i2s_rx_deserializer.sv
  - design/i2s_rx_sample_fifo.sv
  - design/i2s_rx_regs.sv
  - design/i2s_rx_top.sv
  - target: simulation
    files:
      - sim/i2s_rx_monitor.sv
      - sim/i2s_rx_checker.sv
      - sim/i2s_rx_tb.sv

/* design/i2s_rx_deserializer.sv */
`timescale 1ns/100ps
`default_nettype none

module i2s_rx_deserializer
    import i2s_rx_pkg::*;
#(
    parameter int DATA_W = 16                       // Bits per channel slot
)
(
    input  wire logic   clk,
    input  wire logic   rst,
    input  wire logic   sck,                        // I2S bit clock, async to clk
    input  wire logic   ws,                         // Word select, low is left
    input  wire logic   sd,                         // Serial data, MSB first
    input  wire logic   rx_enable,
    output logic        pair_valid,                 // One-cycle strobe per frame
    output sample_pair_t pair
);

    // Bit positions inside the synchronizer bundle
    localparam int SCK_B = 2;
    localparam int WS_B  = 1;
    localparam int SD_B  = 0;

    logic [2:0] sync_q0;                            // First capture, may go metastable
    logic [2:0] sync_q1;                            // Settled value
    logic       sck_q2;                             // One clk older, for the sck edge

    logic bit_stb;                                  // Rising sck seen in clk domain
    logic ws_s;
    logic sd_s;
    logic chan_q;                                   // ws from the previous bit, 1 = right
    logic left_start;                               // ws fell, new left word begins

    logic armed;                                    // Enabled, waiting for a left start
    logic active;                                   // Capturing bits

    logic [DATA_W-1:0] left_sh;
    logic [DATA_W-1:0] right_sh;

    ////////////////////
    // Synchronizers
    ////////////////////

    // All three lines go through the same two flops so ws and sd
    // stay aligned with the sck edge that samples them
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            sync_q0 <= '0;
            sync_q1 <= '0;
            sck_q2  <= 1'b0;
        end
        else
        begin
            sync_q0 <= {sck, ws, sd};
            sync_q1 <= sync_q0;
            sck_q2  <= sync_q1[SCK_B];
        end
    end

    assign bit_stb = sync_q1[SCK_B] & ~sck_q2;     // 0 -> 1 on sck
    assign ws_s    = sync_q1[WS_B];
    assign sd_s    = sync_q1[SD_B];

    // Right slot just ended and ws now says left
    assign left_start = bit_stb & chan_q & ~ws_s;

    // Channel flag lags ws by one bit, per the I2S one-bit delay
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            chan_q <= 1'b0;
        else if (bit_stb)
            chan_q <= ws_s;
    end

    ////////////////////
    // Arming
    ////////////////////

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            armed  <= 1'b0;
            active <= 1'b0;
        end
        else if (!rx_enable)                        // Back to idle straight away
        begin
            armed  <= 1'b0;
            active <= 1'b0;
        end
        else if (!armed && !active)
            armed <= 1'b1;
        else if (armed && left_start)               // Frame boundary found
        begin
            armed  <= 1'b0;
            active <= 1'b1;
        end
    end

    ////////////////////
    // Shift registers
    ////////////////////

    // The bit sampled with a left start is the right LSB, so the
    // first one after arming is skipped since active is still low
    always_ff @(posedge clk)
    begin
        if (active && bit_stb)
        begin
            if (!chan_q)
                left_sh <= {left_sh[DATA_W-2:0], sd_s};
            else
                right_sh <= {right_sh[DATA_W-2:0], sd_s};
        end
    end

    // Frame done when ws falls after a right word
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            pair_valid <= 1'b0;
        else
            pair_valid <= active & rx_enable & left_start;
    end

    // Right LSB arrives with the strobe itself, so merge it in here
    always_ff @(posedge clk)
    begin
        if (active && left_start)
        begin
            pair.left  <= left_sh;
            pair.right <= {right_sh[DATA_W-2:0], sd_s};
        end
    end

endmodule

`default_nettype wire

/* design/i2s_rx_pkg.sv */
`default_nettype none

package i2s_rx_pkg;

    ////////////////////
    // Audio word layout
    ////////////////////

    parameter int DATA_W = 16;                      // Default audio word width

    // One stereo frame as it leaves the deserializer
    typedef struct packed {
        logic [DATA_W-1:0] left;                    // Upper half
        logic [DATA_W-1:0] right;                   // Lower half
    } sample_pair_t;

    ////////////////////
    // Register view
    ////////////////////

    // Status word, enable lands on bit 0 like the CTRL enable
    typedef struct packed {
        logic [19:0] pad;                           // Reads as zero
        logic [7:0]  level;                         // Pairs held in the FIFO
        logic        full;
        logic        empty;
        logic        overrun;                       // Sticky until CTRL bit 1 write
        logic        enable;                        // Current receiver enable
    } rx_status_t;

    // Read data bus, decoded by address
    typedef union packed {
        rx_status_t   status;                       // CTRL and STATUS reads
        sample_pair_t pair;                         // DATA reads
    } reg_rdata_u;

    // Register map
    localparam logic [1:0] REG_CTRL   = 2'd0;      // Bit 0 enable, bit 1 overrun clear
    localparam logic [1:0] REG_STATUS = 2'd1;
    localparam logic [1:0] REG_DATA   = 2'd2;      // Read pops one pair

    // CTRL write bits
    localparam int CTRL_EN_BIT  = 0;
    localparam int CTRL_CLR_BIT = 1;

endpackage

`default_nettype wire

/* design/i2s_rx_regs.sv */
`timescale 1ns/100ps
`default_nettype none

module i2s_rx_regs
    import i2s_rx_pkg::*;
#(
    parameter  int FIFO_DEPTH = 4,
    localparam int LVL_W      = $clog2(FIFO_DEPTH + 1)
)
(
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          reg_wr,          // Single-cycle strobes
    input  wire logic          reg_rd,
    input  wire logic [1:0]    reg_addr,
    input  wire logic [31:0]   reg_wdata,
    input  wire sample_pair_t  head,            // FIFO side
    input  wire logic [LVL_W-1:0] level,
    input  wire logic          empty,
    input  wire logic          full,
    input  wire logic          overrun,         // Drop strobe from the FIFO
    output reg_rdata_u         reg_rdata,
    output logic               reg_rvalid,      // One cycle after reg_rd
    output logic               rx_enable,
    output logic               pop
);

    logic       ovr_sticky;                     // Holds until cleared through CTRL
    logic       ctrl_wr;
    logic       ovr_clr;
    reg_rdata_u rdata_nxt;

    assign ctrl_wr = reg_wr & (reg_addr == REG_CTRL);
    assign ovr_clr = ctrl_wr & reg_wdata[CTRL_CLR_BIT];

    ////////////////////
    // Control state
    ////////////////////

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            rx_enable <= 1'b0;
        else if (ctrl_wr)
            rx_enable <= reg_wdata[CTRL_EN_BIT];
    end

    // A drop in the same cycle as a clear keeps the flag set
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            ovr_sticky <= 1'b0;
        else if (overrun)
            ovr_sticky <= 1'b1;
        else if (ovr_clr)
            ovr_sticky <= 1'b0;
    end

    ////////////////////
    // Read path
    ////////////////////

    // Pop only when there is something to take
    assign pop = reg_rd & (reg_addr == REG_DATA) & ~empty;

    always_comb
    begin
        rdata_nxt = '0;                         // Unmapped addresses read zero
        case (reg_addr)
            REG_CTRL:
            begin
                rdata_nxt.status.enable = rx_enable;    // Clear bit reads back 0
            end
            REG_STATUS:
            begin
                rdata_nxt.status.enable  = rx_enable;
                rdata_nxt.status.overrun = ovr_sticky;
                rdata_nxt.status.empty   = empty;
                rdata_nxt.status.full    = full;
                rdata_nxt.status.level   = 8'(level);   // Zero extended
            end
            REG_DATA:
            begin
                if (!empty)
                    rdata_nxt.pair = head;              // Empty FIFO reads zero
            end
            default:
            begin
                rdata_nxt = '0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            reg_rvalid <= 1'b0;
        else
            reg_rvalid <= reg_rd;
    end

    // Data word is only looked at with reg_rvalid
    always_ff @(posedge clk)
    begin
        if (reg_rd)
            reg_rdata <= rdata_nxt;
    end

endmodule

`default_nettype wire

/* design/i2s_rx_sample_fifo.sv */
`timescale 1ns/100ps
`default_nettype none

module i2s_rx_sample_fifo
    import i2s_rx_pkg::*;
#(
    parameter  int FIFO_DEPTH = 4,
    localparam int PTR_W      = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1,
    localparam int LVL_W      = $clog2(FIFO_DEPTH + 1)
)
(
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          push,            // From deserializer, no back-pressure
    input  wire sample_pair_t  push_data,
    input  wire logic          pop,             // Caller checks empty first
    output sample_pair_t       head,            // Oldest pair, valid when not empty
    output logic [LVL_W-1:0]   level,
    output logic               empty,
    output logic               full,
    output logic               overrun          // One-cycle strobe on a dropped pair
);

    sample_pair_t mem [FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;

    // A pop in the same cycle frees the slot being written
    assign do_push = push & (~full | pop);

    assign empty = (level == '0);
    assign full  = (level == LVL_W'(FIFO_DEPTH));
    assign head  = mem[rd_ptr];

    // Storage only, no reset needed on payload
    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    // Pointers wrap at FIFO_DEPTH, depth need not be a power of two
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        end
    end

    // Level and drop strobe
    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            level   <= '0;
            overrun <= 1'b0;
        end
        else
        begin
            case ({do_push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;        // Idle or push with pop
            endcase
            overrun <= push & ~do_push;         // New pair lost
        end
    end

endmodule

`default_nettype wire

/* design/i2s_rx_top.sv */
`timescale 1ns/100ps
`default_nettype none

module i2s_rx_top
    import i2s_rx_pkg::*;
#(
    parameter  int DATA_W     = 16,             // Audio word width
    parameter  int FIFO_DEPTH = 4,              // Pairs buffered
    localparam int LVL_W      = $clog2(FIFO_DEPTH + 1)
)
(
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        sck,               // I2S lines from the transmitter
    input  wire logic        ws,
    input  wire logic        sd,
    input  wire logic        reg_wr,            // Register port
    input  wire logic        reg_rd,
    input  wire logic [1:0]  reg_addr,
    input  wire logic [31:0] reg_wdata,
    output reg_rdata_u       reg_rdata,
    output logic             reg_rvalid
);

    logic             rx_enable;
    logic             pair_valid;
    sample_pair_t     pair;
    sample_pair_t     head;
    logic [LVL_W-1:0] level;
    logic             empty;
    logic             full;
    logic             overrun;
    logic             pop;

    // Serial to parallel
    i2s_rx_deserializer #(
        .DATA_W     (DATA_W)
    ) u_deser (
        .clk        (clk),
        .rst        (rst),
        .sck        (sck),
        .ws         (ws),
        .sd         (sd),
        .rx_enable  (rx_enable),
        .pair_valid (pair_valid),
        .pair       (pair)
    );

    // Pair buffer
    i2s_rx_sample_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .rst        (rst),
        .push       (pair_valid),
        .push_data  (pair),
        .pop        (pop),
        .head       (head),
        .level      (level),
        .empty      (empty),
        .full       (full),
        .overrun    (overrun)
    );

    // Control and status
    i2s_rx_regs #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_regs (
        .clk        (clk),
        .rst        (rst),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .head       (head),
        .level      (level),
        .empty      (empty),
        .full       (full),
        .overrun    (overrun),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .rx_enable  (rx_enable),
        .pop        (pop)
    );

endmodule

`default_nettype wire

/* sim/i2s_rx_cases.txt */
# name frames enable left right level overrun drain (left and right in hex, first frame only)
# later frames use LCG words, counts assume a FIFO depth of 4
reset_state      0 0 0000 0000 0 0 1
disabled_frames  3 0 1111 2222 0 0 1
known_pair       1 1 a5c3 3c5a 1 0 1
fill_depth       4 1 0f1e 2d3c 4 0 1
overrun_drop     6 1 4b5a 6978 4 1 1
fill_before_stop 2 1 8796 a5b4 2 0 0
stop_midstream   3 0 c3d2 e1f0 2 0 1

/* sim/i2s_rx_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module i2s_rx_checker #(
    parameter  int FIFO_DEPTH = 4,
    localparam int LVL_W      = $clog2(FIFO_DEPTH + 1)
)
(
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic [LVL_W-1:0] level,
    input  wire logic             empty,
    input  wire logic             pop,
    input  wire logic             push,         // pair_valid as seen by the FIFO
    input  wire logic             reg_rd,
    input  wire logic             reg_rvalid
);

    int fail_count = 0;                         // Failed assertion tally

    level_bound: assert property (@(posedge clk) disable iff (!rst)
        level <= LVL_W'(FIFO_DEPTH))
    else
    begin
        $error("FIFO level above its depth");
        fail_count++;
    end

    pop_not_empty: assert property (@(posedge clk) disable iff (!rst)
        pop |-> !empty)
    else
    begin
        $error("Pop issued while the FIFO was empty");
        fail_count++;
    end

    // Read strobe and valid pair up one to one
    rvalid_follows: assert property (@(posedge clk) disable iff (!rst)
        reg_rd |=> reg_rvalid)
    else
    begin
        $error("reg_rvalid missing one cycle after reg_rd");
        fail_count++;
    end

    rvalid_caused: assert property (@(posedge clk) disable iff (!rst)
        reg_rvalid |-> $past(reg_rd))
    else
    begin
        $error("reg_rvalid without a reg_rd the cycle before");
        fail_count++;
    end

    push_single: assert property (@(posedge clk) disable iff (!rst)
        push |=> !push)
    else
    begin
        $error("pair_valid high on two cycles in a row");
        fail_count++;
    end

endmodule

// FIFO side, no register strobes here
bind i2s_rx_sample_fifo i2s_rx_checker #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo_chk (
    .clk        (clk),
    .rst        (rst),
    .level      (level),
    .empty      (empty),
    .pop        (pop),
    .push       (push),
    .reg_rd     (1'b0),
    .reg_rvalid (1'b0)
);

// Register side
bind i2s_rx_regs i2s_rx_checker #(.FIFO_DEPTH(FIFO_DEPTH)) u_regs_chk (
    .clk        (clk),
    .rst        (rst),
    .level      (level),
    .empty      (empty),
    .pop        (pop),
    .push       (1'b0),
    .reg_rd     (reg_rd),
    .reg_rvalid (reg_rvalid)
);

`default_nettype wire

/* sim/i2s_rx_monitor.sv */
`timescale 1ns/100ps
`default_nettype none

module i2s_rx_monitor
    import i2s_rx_pkg::*;
(
    input  wire logic            clk,
    input  wire logic            reg_rd,
    input  wire logic            reg_rvalid,
    input  wire reg_rdata_u      reg_rdata,
    input  wire logic [31:0]     exp_data,          // Sampled with reg_rd
    input  wire logic [8*24-1:0] test_name,
    input  wire logic            test_done,         // One-cycle pulse per case
    input  wire logic            report,            // End of run
    output int                   error_count
);

    logic [31:0] pending[$];                        // Expected words, oldest first
    logic [31:0] expected;
    int          test_reads   = 0;
    int          test_errors  = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    int          total_reads  = 0;

    always @(posedge clk)
    begin
        // Read data from a strobe one cycle back
        if (reg_rvalid)
        begin
            if (pending.size() == 0)
            begin
                $display("Read data came back in test %0s with no read pending", test_name);
                error_count++;
                test_errors++;
            end
            else
            begin
                expected = pending.pop_front();
                test_reads++;
                total_reads++;
                if (reg_rdata !== expected)
                begin
                    $display("CHECK FAILED test %0s expected %08h actual %08h",
                             test_name, expected, reg_rdata);
                    error_count++;
                    test_errors++;
                end
            end
        end
        if (reg_rd)
            pending.push_back(exp_data);

        if (test_done)
        begin
            tests_run++;
            if (test_errors == 0)
                $display("test %0s passed, %0d reads checked", test_name, test_reads);
            else
            begin
                tests_failed++;
                $display("test %0s failed, %0d of %0d reads wrong",
                         test_name, test_errors, test_reads);
            end
            test_reads  = 0;
            test_errors = 0;
        end

        if (report)
            $display("tests %0d, failed %0d, reads %0d, read errors %0d",
                     tests_run, tests_failed, total_reads, error_count);
    end

endmodule

`default_nettype wire

/* sim/i2s_rx_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module i2s_rx_tb
    import i2s_rx_pkg::*;
#(
    parameter int FIFO_DEPTH = 4,                   // Frame counts in the cases file assume 4
    parameter int TIMEOUT    = 2000                 // Clock cycles allowed per wait
);

    logic            clk;
    logic            rst;
    logic            sck;
    logic            ws;
    logic            sd;
    logic            reg_wr;
    logic            reg_rd;
    logic [1:0]      reg_addr;
    logic [31:0]     reg_wdata;
    reg_rdata_u      reg_rdata;
    logic            reg_rvalid;

    logic [8*24-1:0] test_name;                     // Current case, shown by the monitor
    logic [31:0]     exp_data;                      // Travels with reg_rd
    logic            test_done;
    logic            report;
    int              read_errors;

    logic [31:0]     lcg_state  = 32'd92800;
    logic            timed_out  = 1'b0;
    logic            file_error = 1'b0;
    logic            enabled    = 1'b0;             // Enable as last written
    int              captures   = 0;                // pair_valid pulses so far
    logic [31:0]     model[$];                      // Pairs the FIFO should hold, oldest first

    i2s_rx_top #(
        .DATA_W     (DATA_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) DUT (.*);

    i2s_rx_monitor u_mon (.*, .error_count(read_errors));

    always #20 clk = ~clk;                          // 40 ns period

    always @(posedge clk)
    begin
        if (DUT.u_deser.pair_valid)
            captures <= captures + 1;
    end

    function automatic logic [DATA_W-1:0] next_random_word();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[30:15];                    // Upper bits, low ones cycle fast
    endfunction

    // STATUS layout built from the field rules
    function automatic logic [31:0] status_word(input int lvl, input int ovr, input int en);
        rx_status_t st;
        st         = '0;
        st.enable  = (en != 0);
        st.overrun = (ovr != 0);
        st.empty   = (lvl == 0);
        st.full    = (lvl == FIFO_DEPTH);
        st.level   = 8'(lvl);
        return st;
    endfunction

    ////////////////////
    // Register port
    ////////////////////

    task automatic write_reg(input logic [1:0] addr, input logic [31:0] data);
        @(posedge clk);
        reg_wr    <= 1'b1;
        reg_addr  <= addr;
        reg_wdata <= data;
        @(posedge clk);
        reg_wr <= 1'b0;
    endtask

    task automatic read_reg(input logic [1:0] addr, input logic [31:0] expected);
        int n;
        if (timed_out)
            return;                                 // Run is already winding down
        @(posedge clk);
        reg_rd   <= 1'b1;
        reg_addr <= addr;
        exp_data <= expected;
        @(posedge clk);
        reg_rd <= 1'b0;
        n = 0;
        do
        begin
            @(posedge clk);
            n++;
        end
        while (!reg_rvalid && n < TIMEOUT);
        if (!reg_rvalid)
        begin
            $display("Timeout waiting for read data in test %0s", test_name);
            timed_out = 1'b1;
        end
    endtask

    ////////////////////
    // I2S transmitter
    ////////////////////

    // One bit slot of 8 clocks, ws and sd change on the falling sck
    task automatic send_bit(input logic ws_bit, input logic sd_bit);
        @(posedge clk);
        sck <= 1'b0;
        ws  <= ws_bit;
        sd  <= sd_bit;
        repeat (4) @(posedge clk);
        sck <= 1'b1;                                // Receiver samples here
        repeat (3) @(posedge clk);
    endtask

    // ws leads the slot by one bit
    task automatic send_frame(input logic [DATA_W-1:0] l, input logic [DATA_W-1:0] r);
        for (int i = DATA_W - 1; i >= 0; i--)
            send_bit(i == 0, l[i]);                 // Rises on the left LSB
        for (int i = DATA_W - 1; i >= 0; i--)
            send_bit(i != 0, r[i]);                 // Falls on the right LSB
    endtask

    task automatic wait_captures(input int target);
        int n;
        n = 0;
        while (captures < target && n < TIMEOUT)
        begin
            @(posedge clk);
            n++;
        end
        if (captures < target)
        begin
            $display("Timeout waiting for %0d captured frames in test %0s", target, test_name);
            timed_out = 1'b1;
        end
    endtask

    task automatic finish_test();
        @(posedge clk);
        test_done <= 1'b1;
        @(posedge clk);
        test_done <= 1'b0;
        @(posedge clk);                             // Monitor done with this name
    endtask

    initial
    begin
        string line;
        int fd;
        int nframes;
        int en;
        int exp_level;
        int exp_ovr;
        int drain;
        int base;
        int chk_errors;
        logic [DATA_W-1:0] l;
        logic [DATA_W-1:0] r;
        logic [DATA_W-1:0] fl;
        logic [DATA_W-1:0] fr;

        clk       = 1'b0;
        rst       = 1'b0;
        sck       = 1'b0;
        ws        = 1'b0;
        sd        = 1'b0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = '0;
        reg_wdata = '0;
        exp_data  = '0;
        test_name = '0;
        test_done = 1'b0;
        report    = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;

        fd = $fopen("sim/i2s_rx_cases.txt", "r");
        if (fd == 0)
        begin
            $display("Could not open the cases file sim/i2s_rx_cases.txt");
            file_error = 1'b1;
        end
        while (fd != 0 && !$feof(fd) && !timed_out)
        begin
            if ($fgets(line, fd) == 0 || line.len() < 2 || line[0] == "#")
                continue;                           // Blank, comment or end of file
            if ($sscanf(line, "%s %d %d %h %h %d %d %d", test_name, nframes, en, l, r,
                        exp_level, exp_ovr, drain) != 8)
            begin
                $display("Malformed line in the cases file: %s", line);
                file_error = 1'b1;
                continue;
            end
            if ((en != 0) != enabled)
                write_reg(REG_CTRL, 32'(en));
            if (en != 0 && !enabled)
                send_frame(next_random_word(), next_random_word());  // Only arms
            enabled = (en != 0);
            base    = captures;
            for (int f = 0; f < nframes; f++)
            begin
                fl = l;
                fr = r;
                if (f != 0)
                begin
                    fl = next_random_word();
                    fr = next_random_word();
                end
                send_frame(fl, fr);
                if (enabled && model.size() < FIFO_DEPTH)
                    model.push_back({fl, fr});      // Overflow drops the newest
            end
            @(posedge clk);
            sck <= 1'b0;                            // Park the bit clock
            repeat (8) @(posedge clk);              // Room for a stray capture to land
            wait_captures(base + (enabled ? nframes : 0));
            read_reg(REG_STATUS, status_word(exp_level, exp_ovr, en));
            if (exp_ovr != 0)
            begin
                write_reg(REG_CTRL, 32'(en) | 32'h2);
                read_reg(REG_STATUS, status_word(exp_level, 0, en));
            end
            if (drain != 0)
            begin
                while (model.size() > 0 && !timed_out)
                    read_reg(REG_DATA, model.pop_front());
                read_reg(REG_DATA, 32'h0);          // Empty FIFO reads zero
                read_reg(REG_STATUS, status_word(0, 0, en));
            end
            if (!timed_out)
                finish_test();
        end
        if (fd != 0)
            $fclose(fd);

        @(posedge clk);
        report <= 1'b1;
        @(posedge clk);
        report <= 1'b0;
        @(posedge clk);
        chk_errors = DUT.u_fifo.u_fifo_chk.fail_count + DUT.u_regs.u_regs_chk.fail_count;
        if (timed_out || file_error || read_errors != 0 || chk_errors != 0)
            $display("** FAIL **");
        else
            $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
design/i2s_rx_pkg.sv
design/i2s_rx_deserializer.sv
design/i2s_rx_sample_fifo.sv
design/i2s_rx_regs.sv
design/i2s_rx_top.sv
sim/i2s_rx_monitor.sv
sim/i2s_rx_checker.sv
sim/i2s_rx_tb.sv
